// File: logic/lpif_params.svh
// LPIF adapter sizing macros

`ifndef LPIF_PARAMS_SVH
`define LPIF_PARAMS_SVH

////////////////////////////////////////
// LPIF side
////////////////////////////////////////

// Bytes in one LPIF beat
`define LPIF_DATA_BYTES 4

////////////////////////////////////////
// AIB side
////////////////////////////////////////

`define AIB_LANES 4           // Lanes per AIB word
`define AIB_BITS_PER_LANE 16  // Bits per lane per lclk

// Consecutive settled cycles of the far side before link-up
`define LINK_SETTLE_CYCLES 8

`endif

// File: logic/lpif_pkg.sv
// LPIF adapter types

`default_nettype none

`include "lpif_params.svh"

package lpif_pkg;

  typedef logic [`LPIF_DATA_BYTES*8-1:0] lpif_data_t;  // One LPIF beat
  typedef logic [7:0] stream_t;
  typedef logic [`AIB_LANES-1:0] lane_mask_t;          // One bit per lane

  // Full AIB transfer, lane 0 in the low bits
  typedef logic [`AIB_LANES*`AIB_BITS_PER_LANE-1:0] aib_word_t;

  // Wide enough to hold the settle count itself
  typedef logic [3:0] settle_cnt_t;

  // LPIF state encodings
  typedef enum logic [3:0]
  {
    RESET     = 4'b0000,
    ACTIVE    = 4'b0001,
    LINKERROR = 4'b1010
  } link_state_e;

endpackage

`default_nettype wire

// File: logic/lpif_link_if.sv
// AIB link status bundle

`timescale 1ns/1ps
`default_nettype none

interface lpif_link_if;

  logic link_up;    // Far side settled
  logic tx_online;
  logic rx_online;
  logic phy_err;    // Word alignment error seen

  // Bring-up control owns every status bit
  modport ctl
  (
    output link_up,
    output tx_online,
    output rx_online,
    output phy_err
  );

  modport lsm
  (
    input link_up,
    input phy_err
  );

  modport tx
  (
    input tx_online
  );

  modport rx
  (
    input rx_online
  );

endinterface

`default_nettype wire

// File: logic/lpif_ctl.sv
// AIB bring-up control

`timescale 1ns/1ps
`default_nettype none

`include "lpif_params.svh"

module lpif_ctl
(
  input  logic                 lclk,
  input  logic                 reset,
  input  logic                 fs_mac_rdy,
  input  lpif_pkg::lane_mask_t ms_tx_transfer_en,
  input  lpif_pkg::lane_mask_t sl_rx_transfer_en,
  input  lpif_pkg::lane_mask_t wa_error,
  output logic                 ns_mac_rdy,
  output lpif_pkg::lane_mask_t ns_adapter_rstn,
  lpif_link_if.ctl             link
);

  lpif_pkg::settle_cnt_t settle_cnt;
  logic                  qualify;
  logic                  cnt_full;
  logic                  cnt_last;    // Next qualifying edge completes the run
  logic                  link_up_q;
  logic                  phy_err_q;

  ////////////////////////////////////////
  // Adapter reset release
  ////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      ns_mac_rdy      <= 1'b0;
      ns_adapter_rstn <= '0;
    end
    else
    begin
      ns_mac_rdy      <= 1'b1;
      ns_adapter_rstn <= '1;  // All lanes out of reset
    end
  end

  ////////////////////////////////////////
  // Link-up qualifier
  ////////////////////////////////////////

  // Far side ready with every lane enabled both ways
  assign qualify  = fs_mac_rdy && (&ms_tx_transfer_en) && (&sl_rx_transfer_en);
  assign cnt_full = (settle_cnt == lpif_pkg::settle_cnt_t'(`LINK_SETTLE_CYCLES));
  assign cnt_last = (settle_cnt >= lpif_pkg::settle_cnt_t'(`LINK_SETTLE_CYCLES - 1));

  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      settle_cnt <= '0;
      link_up_q  <= 1'b0;
    end
    else if (qualify)
    begin
      if (!cnt_full)
      begin
        settle_cnt <= settle_cnt + lpif_pkg::settle_cnt_t'(1);  // Saturates at full
      end
      link_up_q <= cnt_last;
    end
    else
    begin
      settle_cnt <= '0;    // Any glitch restarts the run
      link_up_q  <= 1'b0;
    end
  end

  // Error summary across lanes
  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      phy_err_q <= 1'b0;
    end
    else
    begin
      phy_err_q <= |wa_error;
    end
  end

  assign link.link_up   = link_up_q;
  assign link.tx_online = link_up_q;
  assign link.rx_online = link_up_q;
  assign link.phy_err   = phy_err_q;

endmodule

`default_nettype wire

// File: logic/lpif_lsm.sv
// LPIF link state machine

`timescale 1ns/1ps
`default_nettype none

module lpif_lsm
(
  input  logic                  lclk,
  input  logic                  reset,
  input  lpif_pkg::link_state_e lp_state_req,
  input  logic                  lp_linkerror,
  lpif_link_if.lsm              link,
  output lpif_pkg::link_state_e pl_state_sts,
  output logic                  pl_lnk_up,
  output logic                  lsm_active
);

  lpif_pkg::link_state_e state;
  lpif_pkg::link_state_e state_nxt;

  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      state <= lpif_pkg::RESET;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      lpif_pkg::RESET:
      begin
        // Only leave reset once the AIB link is qualified
        if (lp_state_req == lpif_pkg::ACTIVE && link.link_up)
        begin
          state_nxt = lpif_pkg::ACTIVE;
        end
      end
      lpif_pkg::ACTIVE:
      begin
        if (link.phy_err || lp_linkerror || !link.link_up)
        begin
          state_nxt = lpif_pkg::LINKERROR;  // Errors win over requests
        end
        else if (lp_state_req == lpif_pkg::RESET)
        begin
          state_nxt = lpif_pkg::RESET;
        end
      end
      lpif_pkg::LINKERROR:
      begin
        if (lp_state_req == lpif_pkg::RESET)
        begin
          state_nxt = lpif_pkg::RESET;
        end
      end
      default:
      begin
        state_nxt = lpif_pkg::RESET;
      end
    endcase
  end

  assign pl_state_sts = state;
  assign pl_lnk_up    = (state == lpif_pkg::ACTIVE);
  assign lsm_active   = (state == lpif_pkg::ACTIVE);

endmodule

`default_nettype wire

// File: logic/lpif_tx_framer.sv
// Downstream AIB framer

`timescale 1ns/1ps
`default_nettype none

`include "lpif_params.svh"

module lpif_tx_framer
(
  input  logic                 lclk,
  input  logic                 reset,
  input  logic                 lp_irdy,
  input  logic                 lp_valid,
  input  lpif_pkg::lpif_data_t lp_data,
  input  lpif_pkg::stream_t    lp_stream,
  input  logic                 lsm_active,
  lpif_link_if.tx              link,
  output logic                 pl_trdy,
  output lpif_pkg::aib_word_t  data_in_f
);

  logic                accept;
  lpif_pkg::aib_word_t frame;

  assign pl_trdy = lsm_active && link.tx_online;
  assign accept  = lp_irdy && lp_valid && pl_trdy;

  // Data byte i in the low byte of lane i
  always_comb
  begin
    frame = '0;
    for (int i = 0; i < `LPIF_DATA_BYTES; i++)
    begin
      frame[i*`AIB_BITS_PER_LANE +: 8] = lp_data[i*8 +: 8];
    end
    frame[8 +: 8] = lp_stream;                 // Lane 0 high byte
    frame[`AIB_BITS_PER_LANE + 8] = 1'b1;      // Valid flag, lane 1 bit 8
  end

  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      data_in_f <= '0;
    end
    else if (accept)
    begin
      data_in_f <= frame;
    end
    else
    begin
      data_in_f <= '0;  // Idle word
    end
  end

endmodule

`default_nettype wire

// File: logic/lpif_rx_deframer.sv
// Upstream AIB deframer

`timescale 1ns/1ps
`default_nettype none

`include "lpif_params.svh"

module lpif_rx_deframer
(
  input  logic                 lclk,
  input  logic                 reset,
  input  lpif_pkg::aib_word_t  dout_lpbk,
  lpif_link_if.rx              link,
  output logic                 pl_valid,
  output lpif_pkg::lpif_data_t pl_data,
  output lpif_pkg::stream_t    pl_stream
);

  lpif_pkg::aib_word_t rx_word;

  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      rx_word <= '0;
    end
    else
    begin
      rx_word <= dout_lpbk;
    end
  end

  // Low byte of each lane back into the beat
  always_comb
  begin
    pl_data = '0;
    for (int i = 0; i < `LPIF_DATA_BYTES; i++)
    begin
      pl_data[i*8 +: 8] = rx_word[i*`AIB_BITS_PER_LANE +: 8];
    end
  end

  assign pl_stream = rx_word[8 +: 8];

  // Nothing reaches the link layer while offline
  assign pl_valid = rx_word[`AIB_BITS_PER_LANE + 8] && link.rx_online;

endmodule

`default_nettype wire

// File: logic/lpif_lpbk.sv
// AIB loopback path

`timescale 1ns/1ps
`default_nettype none

module lpif_lpbk
(
  input  logic                lclk,
  input  logic                reset,
  input  logic                lpbk_en,
  input  lpif_pkg::aib_word_t data_in_f,
  input  lpif_pkg::aib_word_t dout,
  output lpif_pkg::aib_word_t dout_lpbk
);

  lpif_pkg::aib_word_t lpbk_q;  // Transmit word, one cycle late

  always_ff @(posedge lclk)
  begin
    if (reset)
    begin
      lpbk_q <= '0;
    end
    else
    begin
      lpbk_q <= data_in_f;
    end
  end

  // Far side word passes straight through
  assign dout_lpbk = lpbk_en ? lpbk_q : dout;

endmodule

`default_nettype wire

// File: logic/lpif.sv
// LPIF to AIB adapter top

`timescale 1ns/1ps
`default_nettype none

module lpif
(
  // LPIF side
  input  logic                  lclk,
  input  logic                  reset,
  input  logic                  lp_irdy,
  input  logic                  lp_valid,
  input  lpif_pkg::lpif_data_t  lp_data,
  input  lpif_pkg::stream_t     lp_stream,
  input  lpif_pkg::link_state_e lp_state_req,
  input  logic                  lp_linkerror,
  input  logic                  lpbk_en,
  output logic                  pl_trdy,
  output logic                  pl_valid,
  output lpif_pkg::lpif_data_t  pl_data,
  output lpif_pkg::stream_t     pl_stream,
  output lpif_pkg::link_state_e pl_state_sts,
  output logic                  pl_lnk_up,

  // AIB side
  input  logic                  fs_mac_rdy,
  input  lpif_pkg::lane_mask_t  ms_tx_transfer_en,
  input  lpif_pkg::lane_mask_t  sl_rx_transfer_en,
  input  lpif_pkg::lane_mask_t  wa_error,
  input  lpif_pkg::aib_word_t   dout,
  output logic                  ns_mac_rdy,
  output lpif_pkg::lane_mask_t  ns_adapter_rstn,
  output lpif_pkg::aib_word_t   data_in_f
);

  logic                lsm_active;
  lpif_pkg::aib_word_t dout_lpbk;  // Receive source after loopback select

  lpif_link_if link_i ();

  ////////////////////////////////////////
  // Control and link state
  ////////////////////////////////////////

  lpif_ctl lpif_ctl_i
  (
    .lclk              (lclk),
    .reset             (reset),
    .fs_mac_rdy        (fs_mac_rdy),
    .ms_tx_transfer_en (ms_tx_transfer_en),
    .sl_rx_transfer_en (sl_rx_transfer_en),
    .wa_error          (wa_error),
    .ns_mac_rdy        (ns_mac_rdy),
    .ns_adapter_rstn   (ns_adapter_rstn),
    .link              (link_i.ctl)
  );

  lpif_lsm lpif_lsm_i
  (
    .lclk         (lclk),
    .reset        (reset),
    .lp_state_req (lp_state_req),
    .lp_linkerror (lp_linkerror),
    .link         (link_i.lsm),
    .pl_state_sts (pl_state_sts),
    .pl_lnk_up    (pl_lnk_up),
    .lsm_active   (lsm_active)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  lpif_tx_framer lpif_tx_framer_i
  (
    .lclk       (lclk),
    .reset      (reset),
    .lp_irdy    (lp_irdy),
    .lp_valid   (lp_valid),
    .lp_data    (lp_data),
    .lp_stream  (lp_stream),
    .lsm_active (lsm_active),
    .link       (link_i.tx),
    .pl_trdy    (pl_trdy),
    .data_in_f  (data_in_f)
  );

  lpif_lpbk lpif_lpbk_i
  (
    .lclk      (lclk),
    .reset     (reset),
    .lpbk_en   (lpbk_en),
    .data_in_f (data_in_f),
    .dout      (dout),
    .dout_lpbk (dout_lpbk)
  );

  lpif_rx_deframer lpif_rx_deframer_i
  (
    .lclk      (lclk),
    .reset     (reset),
    .dout_lpbk (dout_lpbk),
    .link      (link_i.rx),
    .pl_valid  (pl_valid),
    .pl_data   (pl_data),
    .pl_stream (pl_stream)
  );

endmodule

`default_nettype wire

// File: verif/lpif_assertions.sv
// LPIF adapter bound checks

`timescale 1ns/1ps
`default_nettype none

module lpif_assertions
(
  input logic                  lclk,
  input logic                  reset,
  input logic                  trdy,
  input logic                  active,
  input logic                  accept,   // Beat taken this cycle
  input lpif_pkg::aib_word_t   word,
  input lpif_pkg::link_state_e state
);

  ////////////////////////////////////////
  // Framer rules
  ////////////////////////////////////////

  a_trdy_active: assert property (@(posedge lclk) disable iff (reset) trdy |-> active)
    else $error("pl_trdy high outside ACTIVE");

  a_idle_word: assert property (@(posedge lclk) disable iff (reset) !accept |=> word == '0)
    else $error("data_in_f not idle after a cycle with no beat");

  ////////////////////////////////////////
  // State machine rules
  ////////////////////////////////////////

  a_no_reset_to_err: assert property (@(posedge lclk) disable iff (reset)
    state == lpif_pkg::RESET |=> state != lpif_pkg::LINKERROR)
    else $error("RESET went straight to LINKERROR");

endmodule

// Framer instance, state tied to RESET
bind lpif_tx_framer lpif_assertions tx_assert_i
(
  .lclk   (lclk),
  .reset  (reset),
  .trdy   (pl_trdy),
  .active (lsm_active),
  .accept (lp_irdy && lp_valid && pl_trdy),
  .word   (data_in_f),
  .state  (lpif_pkg::RESET)
);

// State machine instance, framing inputs idle
bind lpif_lsm lpif_assertions lsm_assert_i
(
  .lclk   (lclk),
  .reset  (reset),
  .trdy   (1'b0),
  .active (lsm_active),
  .accept (1'b0),
  .word   ('0),
  .state  (state)
);

`default_nettype wire

// File: verif/lpif_tb.sv
// LPIF adapter testbench

`timescale 1ns/1ps
`default_nettype none

`include "lpif_params.svh"

module lpif_tb;

  localparam int MAX_TESTS = 64;

  logic                  lclk;
  logic                  reset;
  logic                  lp_irdy;
  logic                  lp_valid;
  lpif_pkg::lpif_data_t  lp_data;
  lpif_pkg::stream_t     lp_stream;
  lpif_pkg::link_state_e lp_state_req;
  logic                  lp_linkerror;
  logic                  lpbk_en;
  logic                  pl_trdy;
  logic                  pl_valid;
  lpif_pkg::lpif_data_t  pl_data;
  lpif_pkg::stream_t     pl_stream;
  lpif_pkg::link_state_e pl_state_sts;
  logic                  pl_lnk_up;
  logic                  fs_mac_rdy;
  lpif_pkg::lane_mask_t  ms_tx_transfer_en;
  lpif_pkg::lane_mask_t  sl_rx_transfer_en;
  lpif_pkg::lane_mask_t  wa_error;
  lpif_pkg::aib_word_t   dout;
  logic                  ns_mac_rdy;
  lpif_pkg::lane_mask_t  ns_adapter_rstn;
  lpif_pkg::aib_word_t   data_in_f;

  // One entry per stimulus line
  int                   kind_q[MAX_TESTS];
  int                   err_q[MAX_TESTS];     // 1 wa_error, 2 lp_linkerror
  logic                 loop_q[MAX_TESTS];    // lpbk_en for the test
  logic                 flag_q[MAX_TESTS];
  logic                 exp_valid_q[MAX_TESTS];
  logic [3:0]           exp_state_q[MAX_TESTS];
  lpif_pkg::lpif_data_t data_q[MAX_TESTS];
  lpif_pkg::stream_t    stream_q[MAX_TESTS];
  int                   num_tests;
  bit                   loaded;
  int                   errors;
  int                   test_errors;
  int                   failed_tests;

  lpif dut_i (.*);

  initial lclk = 1'b0;
  always #50 lclk = ~lclk;

  ////////////////////////////////////////
  // Frame rule and compares
  ////////////////////////////////////////

  function automatic lpif_pkg::aib_word_t build_frame(input lpif_pkg::lpif_data_t d,
                                                       input lpif_pkg::stream_t s,
                                                       input logic v);
    lpif_pkg::aib_word_t w;
    w = '0;
    w[7:0]   = d[7:0];     // Lane 0
    w[15:8]  = s;
    w[23:16] = d[15:8];    // Lane 1
    w[24]    = v;
    w[39:32] = d[23:16];   // Lane 2
    w[55:48] = d[31:24];   // Lane 3
    return w;
  endfunction

  task automatic check_state(input string name, input lpif_pkg::link_state_e got,
                             input lpif_pkg::link_state_e exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_data(input string name, input lpif_pkg::lpif_data_t got,
                            input lpif_pkg::lpif_data_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_stream(input string name, input lpif_pkg::stream_t got,
                              input lpif_pkg::stream_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_word(input string name, input lpif_pkg::aib_word_t got,
                            input lpif_pkg::aib_word_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic drive_point();
    @(posedge lclk);
    #1;
  endtask

  task automatic wait_state(input lpif_pkg::link_state_e exp, input int limit);
    for (int n = 0; n < limit; n++)
    begin
      @(negedge lclk);
      if (pl_state_sts == exp)
      begin
        break;
      end
    end
    check_state("pl_state_sts", pl_state_sts, exp);
  endtask

  task automatic load_stim(output bit ok);
    int    fd;
    int    cnt;
    int    kind;
    int    lp;
    int    fl;
    int    er;
    int    es;
    int    ev;
    logic [31:0] d;
    logic [7:0]  s;
    string line;
    ok = 1'b0;
    num_tests = 0;
    fd = $fopen("verif/lpif_stim.txt", "r");
    if (fd == 0)
    begin
      return;
    end
    while ($fgets(line, fd) && num_tests < MAX_TESTS)
    begin
      if (line.len() > 1 && line[0] != "#")
      begin
        cnt = $sscanf(line, "%d %h %h %h %h %h %h %h", kind, lp, d, s, fl, er, es, ev);
        if (cnt == 8)
        begin
          kind_q[num_tests]      = kind;
          loop_q[num_tests]      = lp[0];
          data_q[num_tests]      = d;
          stream_q[num_tests]    = s;
          flag_q[num_tests]      = fl[0];
          err_q[num_tests]       = er;
          exp_state_q[num_tests] = es[3:0];
          exp_valid_q[num_tests] = ev[0];
          num_tests++;
        end
      end
    end
    $fclose(fd);
    ok = (num_tests > 0);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic run_bringup(input int t);
    fs_mac_rdy        = 1'b1;
    ms_tx_transfer_en = '1;
    sl_rx_transfer_en = '1;
    lp_state_req      = lpif_pkg::ACTIVE;
    for (int i = 1; i <= `LINK_SETTLE_CYCLES; i++)
    begin
      @(negedge lclk);
      check_state("pl_state_sts", pl_state_sts, lpif_pkg::RESET);
    end
    wait_state(lpif_pkg::link_state_e'(exp_state_q[t]), 2);
    check_bit("pl_lnk_up", pl_lnk_up, 1'b1);
    check_bit("ns_mac_rdy", ns_mac_rdy, 1'b1);
    check_bit("ns_adapter_rstn all ones", &ns_adapter_rstn, 1'b1);
  endtask

  task automatic run_downstream(input int t);
    drive_point();
    lpbk_en   = loop_q[t];
    lp_irdy   = 1'b1;
    lp_valid  = 1'b1;
    lp_data   = data_q[t];
    lp_stream = stream_q[t];
    @(negedge lclk);
    check_bit("pl_trdy", pl_trdy, 1'b1);
    drive_point();
    lp_irdy  = 1'b0;
    lp_valid = 1'b0;
    @(negedge lclk);
    check_word("data_in_f", data_in_f, build_frame(data_q[t], stream_q[t], 1'b1));
  endtask

  task automatic run_upstream(input int t);
    drive_point();
    lpbk_en = loop_q[t];
    dout    = build_frame(data_q[t], stream_q[t], flag_q[t]);
    drive_point();
    dout = '0;
    @(negedge lclk);
    check_data("pl_data", pl_data, data_q[t]);
    check_stream("pl_stream", pl_stream, stream_q[t]);
    check_bit("pl_valid", pl_valid, exp_valid_q[t]);
  endtask

  task automatic run_loopback(input int t);
    drive_point();
    lpbk_en   = loop_q[t];
    lp_irdy   = 1'b1;
    lp_valid  = 1'b1;
    lp_data   = data_q[t];
    lp_stream = stream_q[t];
    drive_point();                // Edge N takes the beat
    lp_irdy  = 1'b0;
    lp_valid = 1'b0;
    @(posedge lclk);
    @(posedge lclk);              // Edge N+2
    @(negedge lclk);
    check_data("pl_data", pl_data, data_q[t]);
    check_stream("pl_stream", pl_stream, stream_q[t]);
    check_bit("pl_valid", pl_valid, exp_valid_q[t]);
    drive_point();
    lpbk_en = 1'b0;
  endtask

  task automatic run_error(input int t);
    drive_point();
    if (err_q[t] == 1)
    begin
      wa_error = 4'b0001;
    end
    else
    begin
      lp_linkerror = 1'b1;
    end
    drive_point();
    wa_error     = '0;
    lp_linkerror = 1'b0;
    wait_state(lpif_pkg::link_state_e'(exp_state_q[t]), 2);
    check_bit("pl_trdy", pl_trdy, 1'b0);
    check_bit("pl_lnk_up", pl_lnk_up, 1'b0);
    // Offered beat must be refused
    drive_point();
    lp_irdy   = 1'b1;
    lp_valid  = 1'b1;
    lp_data   = data_q[t];
    lp_stream = stream_q[t];
    drive_point();
    lp_irdy  = 1'b0;
    lp_valid = 1'b0;
    @(negedge lclk);
    check_word("data_in_f", data_in_f, '0);
    drive_point();
    lp_state_req = lpif_pkg::RESET;
    wait_state(lpif_pkg::RESET, 3);
    drive_point();
    lp_state_req = lpif_pkg::ACTIVE;
    wait_state(lpif_pkg::ACTIVE, 3);
    check_bit("pl_lnk_up", pl_lnk_up, 1'b1);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial
  begin
    bit ok;
    reset             = 1'b1;
    lp_irdy           = 1'b0;
    lp_valid          = 1'b0;
    lp_data           = '0;
    lp_stream         = '0;
    lp_state_req      = lpif_pkg::RESET;
    lp_linkerror      = 1'b0;
    lpbk_en           = 1'b0;
    fs_mac_rdy        = 1'b0;
    ms_tx_transfer_en = '0;
    sl_rx_transfer_en = '0;
    wa_error          = '0;
    dout              = '0;
    errors            = 0;
    failed_tests      = 0;
    load_stim(ok);
    loaded = 1'b1;
    if (!ok)
    begin
      $display("Stimulus file missing or holds no tests");
      $display("Testbench failed");
      $finish;
    end
    else
    begin
      repeat (10) @(posedge lclk);
      #1;
      reset = 1'b0;
      for (int t = 0; t < num_tests; t++)
      begin
        test_errors = 0;
        case (kind_q[t])
          1: run_bringup(t);
          2: run_downstream(t);
          3: run_upstream(t);
          4: run_loopback(t);
          5: run_error(t);
          default:
          begin
            $display("Test %0d has unknown kind %0d", t, kind_q[t]);
            test_errors++;
          end
        endcase
        $display("test %0d kind %0d: %s", t, kind_q[t], (test_errors == 0) ? "ok" : "FAIL");
        errors += test_errors;
        if (test_errors != 0)
        begin
          failed_tests++;
        end
      end
      $display("%0d tests run, %0d failed, %0d check errors", num_tests, failed_tests, errors);
      if (errors == 0)
      begin
        $display("Testbench passed");
      end
      else
      begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

  initial
  begin
    wait (loaded);
    #(num_tests * 40 * 100);
    $display("Watchdog expired before all tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/lpif_stim.txt
# kind lpbk data stream flag err exp_state exp_valid (kind decimal, others hex)
# kind 1 bring-up, 2 downstream, 3 upstream, 4 loopback, 5 error (err 1 wa_error, 2 lp_linkerror)
1 0 00000000 00 0 0 1 0
2 0 12345678 3c 1 0 1 0
2 0 ffffffff ff 1 0 1 0
2 0 00000001 00 1 0 1 0
2 0 a5a55a5a 81 1 0 1 0
3 0 deadbeef 07 1 0 1 1
3 0 cafef00d 42 0 0 1 0
3 0 80000000 ff 1 0 1 1
3 0 0000ffff 10 0 0 1 0
4 1 13579bdf 5e 1 0 1 1
4 1 fedcba98 01 1 0 1 1
4 1 00ff00ff 99 1 0 1 1
5 0 11223344 22 0 1 a 0
5 0 55667788 33 0 2 a 0
2 0 0badc0de 77 1 0 1 0
3 0 76543210 e1 1 0 1 1
4 1 c001d00d 0f 1 0 1 1

// File: files.f
+incdir+logic
logic/lpif_pkg.sv
logic/lpif_link_if.sv
logic/lpif_ctl.sv
logic/lpif_lsm.sv
logic/lpif_tx_framer.sv
logic/lpif_rx_deframer.sv
logic/lpif_lpbk.sv
logic/lpif.sv
verif/lpif_assertions.sv
verif/lpif_tb.sv

// File: Makefile
SIM := obj_dir/Vlpif_tb

.PHONY: all run clean

all: run

$(SIM): files.f $(wildcard logic/*.sv logic/*.svh verif/*.sv)
	verilator --binary --timing --assert --top-module lpif_tb -f files.f

run: $(SIM) verif/lpif_stim.txt
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^Testbench passed$$'

clean:
	rm -rf obj_dir
